/* ucode.hex */
// one 16-bit microcode word per line, in hex, from address 0
// 8xxx calls the word at xxx, other values are primitives or literal data
003C // 000 main: rx?
000B // skz
8005 // call proc
8021 // call jmp
0000 // back to main
003D // 005 proc: rx@
0008 // dup
000B // skz
800A // call nonzero path
000E // undefined, faults on a zero byte
8025 // 00A nonzero: lit 0x300 store
0300
0007
8025 // lit 0x300 fetch
0300
0006
8025 // lit 0x5A xor
005A
0003
8025 // lit 3 +
0003
0001
003E // 016 txwait: tx?
000B // skz
801B // call send
8021 // call jmp
0016
003F // 01B send: tx!
000D // r> drop, own return
0009
000D // r> drop, nonzero return
0009
000F // exit to main
000D // 021 jmp: r> @ >r exit
0006
000C
000F
000D // 025 lit: r> dup 1+ >r @ exit
0008
0005
000C
0006
000F

/* ucpu.f */
design/ucpu_pkg.sv
design/ucode_mem.sv
design/lifo_stack.sv
design/alu.sv
design/ucode_sequencer.sv
design/char_port.sv
design/ucpu_top.sv
verification/tb_clock.sv
verification/ucpu_props.sv
verification/tb_checker.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f ucpu.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 || echo "build or run stopped early"
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/tb_top.sv */
// Testbench top for the microcoded CPU with its character port.
// Inputs change on the falling clock edge; random bytes come from a Galois LFSR.
// A watchdog ends the run if the tests take longer than their byte budget.
`timescale 1ns/1ps

module tb_top import ucpu_pkg::*; ();

    localparam int          NUM_RANDOM    = 40;
    localparam int          NUM_BYTES     = NUM_RANDOM + 3;
    localparam int          BYTE_CYCLES   = 2000;     // generous per-byte budget
    localparam int          MARGIN_CYCLES = 5000;
    localparam logic [31:0] SEED          = 32'h5bea;
    localparam logic [31:0] TAPS          = 32'h80200003;

    logic        clk;
    logic        rst_n;
    logic        rst_req;
    logic        run;
    logic        rx_wr;
    char_t       rx_data;
    logic        tx_busy;
    logic        running;
    logic        status;
    logic        tx_wr;
    char_t       tx_data;
    logic        quiet;
    logic        status_chk;
    logic        status_exp;
    logic        test_end;
    int          test_num;
    int          miss_errors;
    int          tx_count;
    int          chk_errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr;

    tb_clock u_clock (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst_n   (rst_n)
    );

    ucpu_top UUT (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_run     (run),
        .i_rx_wr   (rx_wr),
        .i_rx_data (rx_data),
        .i_tx_busy (tx_busy),
        .o_running (running),
        .o_status  (status),
        .o_tx_wr   (tx_wr),
        .o_tx_data (tx_data)
    );

    tb_checker u_checker (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_run          (run),
        .i_rx_wr        (rx_wr),
        .i_rx_data      (rx_data),
        .i_tx_wr        (tx_wr),
        .i_tx_data      (tx_data),
        .i_running      (running),
        .i_status       (status),
        .i_quiet        (quiet),
        .i_status_chk   (status_chk),
        .i_status_exp   (status_exp),
        .i_test_end     (test_end),
        .i_test_num     (test_num),
        .i_extra_errors (miss_errors),
        .o_tx_count     (tx_count),
        .o_errors       (chk_errors),
        .o_tests_run    (tests_run),
        .o_tests_failed (tests_failed)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic nonzero_byte(output char_t b);
        logic [31:0] v;
        v = '0;
        while (v[7:0] == 8'h00) begin
            take_bits(8, v);
        end
        b = v[7:0];
    endtask

    task automatic send_byte(input char_t b);
        @(negedge clk);
        rx_data = b;
        rx_wr   = 1'b1;
        @(negedge clk);
        rx_wr   = 1'b0;
    endtask

    task automatic await_tx(input int start, input string what);
        int n;
        n = 0;
        while (tx_count == start && n < BYTE_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (tx_count == start) begin
            $display("no o_tx_wr within %0d cycles after %s", BYTE_CYCLES, what);
            miss_errors++;
        end
    endtask

    task automatic check_status(input logic exp);
        @(negedge clk);
        status_exp = exp;
        status_chk = 1'b1;
        @(negedge clk);
        status_chk = 1'b0;
    endtask

    task automatic hold_quiet(input int cycles);
        quiet = 1'b1;
        repeat (cycles) @(negedge clk);
        quiet = 1'b0;
    endtask

    task automatic close_test(input int num);
        @(negedge clk);
        test_num = num;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        repeat (NUM_BYTES * BYTE_CYCLES + MARGIN_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within their cycle budget");
        $display("sim failed");
        $finish;
    end

    initial begin
        char_t       b;
        logic [31:0] v;
        int          start;
        int          n;
        rst_req     = 1'b0;
        run         = 1'b0;
        rx_wr       = 1'b0;
        rx_data     = '0;
        tx_busy     = 1'b0;
        quiet       = 1'b0;
        status_chk  = 1'b0;
        status_exp  = 1'b1;
        test_end    = 1'b0;
        test_num    = 0;
        miss_errors = 0;
        lfsr        = SEED;

        wait (rst_n === 1'b1);
        check_status(1'b1);                  // halted, running low
        run = 1'b1;
        check_status(1'b1);
        close_test(1);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            nonzero_byte(b);
            start = tx_count;
            send_byte(b);
            await_tx(start, "a random byte");
        end
        close_test(2);

        tx_busy = 1'b1;
        take_bits(8, v);
        n = 300 + v[7:0];                    // outlasts the program's rx-to-tx path
        nonzero_byte(b);
        start = tx_count;
        send_byte(b);
        hold_quiet(n);
        tx_busy = 1'b0;
        await_tx(start, "busy dropped");
        close_test(3);

        @(negedge clk);
        run = 1'b0;
        nonzero_byte(b);
        start = tx_count;
        send_byte(b);
        hold_quiet(300);
        check_status(1'b1);
        run = 1'b1;
        await_tx(start, "run rose");
        close_test(4);

        quiet = 1'b1;
        send_byte(8'h00);
        n = 0;
        while (status === 1'b1 && n < BYTE_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (status === 1'b1) begin
            $display("o_status did not fall after the zero byte");
            miss_errors++;
        end
        hold_quiet(300);
        check_status(1'b0);
        rst_req = 1'b1;
        repeat (8) @(negedge clk);
        rst_req = 1'b0;
        check_status(1'b1);
        close_test(5);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 chk_errors + miss_errors);
        if (tests_failed == 0 && chk_errors + miss_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verification/tb_checker.sv */
// Watches the DUT ports and compares transmitted bytes with the byte model.
// Every received nonzero byte b predicts one output byte ((b ^ 0x5A) + 3) mod 256.
// A zero byte predicts a fault and no output.
`timescale 1ns/1ps

module tb_checker import ucpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_run,
    input  logic  i_rx_wr,
    input  char_t i_rx_data,
    input  logic  i_tx_wr,
    input  char_t i_tx_data,
    input  logic  i_running,
    input  logic  i_status,
    input  logic  i_quiet,                   // any o_tx_wr now is an error
    input  logic  i_status_chk,
    input  logic  i_status_exp,
    input  logic  i_test_end,
    input  int    i_test_num,
    input  int    i_extra_errors,            // failures found by the stimulus side
    output int    o_tx_count,
    output int    o_errors,
    output int    o_tests_run,
    output int    o_tests_failed
);

    localparam char_t KEY    = 8'h5A;
    localparam char_t OFFSET = 8'd3;

    char_t exp_q[$];
    int    err_mark;

    function automatic string test_name(input int num);
        case (num)
            1:       return "reset state";
            2:       return "random bytes";
            3:       return "transmitter busy";
            4:       return "run low";
            5:       return "zero byte fault";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        o_tx_count     = 0;
        o_errors       = 0;
        o_tests_run    = 0;
        o_tests_failed = 0;
        err_mark       = 0;
    end

    always @(posedge i_clk) begin
        char_t expected;
        int    total;
        int    errs;                         // failures seen on this edge
        errs = 0;
        if (i_rst_n) begin
            if (i_rx_wr && i_rx_data != 8'h00) begin
                exp_q.push_back((i_rx_data ^ KEY) + OFFSET);
            end
            if (i_tx_wr) begin
                o_tx_count <= o_tx_count + 1;
                if (i_quiet) begin
                    $display("o_tx_wr pulsed at %0d ns while no transmit was allowed", $time);
                    errs++;
                end
                if (exp_q.size() == 0) begin
                    $display("o_tx_wr pulsed at %0d ns with no byte outstanding", $time);
                    errs++;
                end else begin
                    expected = exp_q.pop_front();
                    if (i_tx_data !== expected) begin
                        $display("error at %0d ns: o_tx_data expected 0x%02h actual 0x%02h",
                                 $time, expected, i_tx_data);
                        errs++;
                    end
                end
            end
            if (i_status_chk) begin
                if (i_status !== i_status_exp) begin
                    $display("error at %0d ns: o_status expected %b actual %b",
                             $time, i_status_exp, i_status);
                    errs++;
                end
                if (i_running !== (i_run & i_status_exp)) begin
                    $display("error at %0d ns: o_running expected %b actual %b",
                             $time, i_run & i_status_exp, i_running);
                    errs++;
                end
                if (i_tx_wr !== 1'b0) begin
                    $display("error at %0d ns: o_tx_wr expected 0 actual %b", $time, i_tx_wr);
                    errs++;
                end
            end
        end
        o_errors <= o_errors + errs;
        if (i_test_end) begin
            total = o_errors + errs + i_extra_errors;
            o_tests_run <= o_tests_run + 1;
            if (total != err_mark) begin
                o_tests_failed <= o_tests_failed + 1;
                $display("test %0d %s: failed", i_test_num, test_name(i_test_num));
            end else begin
                $display("test %0d %s: passed", i_test_num, test_name(i_test_num));
            end
            err_mark = total;
        end
    end

endmodule

/* verification/ucpu_props.sv */
// Concurrent checks on the sequencer, attached by bind.
// The transmit strobe is checked at its source, one clock before o_tx_wr.
`timescale 1ns/1ps

module ucpu_props import ucpu_pkg::*; (
    input logic   i_clk,
    input logic   i_rst_n,
    input phase_t i_phase,
    input logic   i_tx_load,
    input logic   i_status
);

    // only fetch may wait, every other phase steps to the next one
    a_phase_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_phase != PH_FETCH) |=> (i_phase == phase_t'($past(i_phase) + 2'd1)))
        else $error("sequencer phase left its four-phase order");

    a_tx_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_tx_load |=> !i_tx_load)
        else $error("transmit strobe high for two cycles in a row");

    a_status_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$rose(i_status))
        else $error("status rose outside of reset");

endmodule

bind ucode_sequencer ucpu_props u_props (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_phase   (phase),
    .i_tx_load (o_tx_load),
    .i_status  (status)
);

/* verification/tb_clock.sv */
// Testbench clock and reset source, 100 ns period.
// Reset is held for 8 cycles after time zero and for as long as i_rst_req is high.
`timescale 1ns/1ps

module tb_clock (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_NS      = 50;
    localparam int RESET_CYCLES = 8;

    logic por_done;

    initial begin
        o_clk    = 1'b0;
        por_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        por_done = 1'b1;                     // release away from the active edge
    end

    always #HALF_NS o_clk = ~o_clk;

    assign o_rst_n = por_done & ~i_rst_req;

endmodule

/* design/ucpu_top.sv */
// Microcoded stack CPU with a byte-wide character port.
// Runs while i_run is high and no fault has occurred.
// i_tx_busy is sampled as a level by tx?, no handshake beyond that.
`timescale 1ns/1ps

module ucpu_top import ucpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_run,
    input  logic  i_rx_wr,
    input  char_t i_rx_data,
    input  logic  i_tx_busy,
    output logic  o_running,
    output logic  o_status,
    output logic  o_tx_wr,
    output char_t o_tx_data
);

    logic    mem_wr;
    addr_t   mem_waddr;
    addr_t   mem_raddr;
    cell_t   mem_wdata;
    cell_t   mem_rdata;
    logic    d_push;
    logic    d_pop;
    cell_t   d_value;
    cell_t   d0;
    cell_t   d1;
    logic    r_push;
    logic    r_pop;
    cell_t   r_value;
    cell_t   r0;
    alu_op_t alu_op;
    cell_t   alu_arg0;
    cell_t   alu_arg1;
    cell_t   alu_data;
    logic    rx_ready;
    logic    rx_take;
    char_t   rx_char;
    logic    tx_load;
    char_t   tx_char;

    ucode_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_run       (i_run),
        .i_rdata     (mem_rdata),
        .i_d0        (d0),
        .i_d1        (d1),
        .i_r0        (r0),
        .i_alu_data  (alu_data),
        .i_rx_ready  (rx_ready),
        .i_rx_char   (rx_char),
        .i_tx_busy   (i_tx_busy),
        .o_mem_wr    (mem_wr),
        .o_mem_waddr (mem_waddr),
        .o_mem_wdata (mem_wdata),
        .o_mem_raddr (mem_raddr),
        .o_d_push    (d_push),
        .o_d_pop     (d_pop),
        .o_d_value   (d_value),
        .o_r_push    (r_push),
        .o_r_pop     (r_pop),
        .o_r_value   (r_value),
        .o_alu_op    (alu_op),
        .o_alu_arg0  (alu_arg0),
        .o_alu_arg1  (alu_arg1),
        .o_rx_take   (rx_take),
        .o_tx_load   (tx_load),
        .o_tx_char   (tx_char),
        .o_running   (o_running),
        .o_status    (o_status)
    );

    ucode_mem u_mem (
        .i_clk   (i_clk),
        .i_wr    (mem_wr),
        .i_waddr (mem_waddr),
        .i_wdata (mem_wdata),
        .i_raddr (mem_raddr),
        .o_rdata (mem_rdata)
    );

    lifo_stack d_stack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (d_push),
        .i_pop   (d_pop),
        .i_data  (d_value),
        .o_s0    (d0),
        .o_s1    (d1)
    );

    lifo_stack r_stack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (r_push),
        .i_pop   (r_pop),
        .i_data  (r_value),
        .o_s0    (r0),
        .o_s1    ()                          // no opcode reads the second return cell
    );

    alu u_alu (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_op    (alu_op),
        .i_arg0  (alu_arg0),
        .i_arg1  (alu_arg1),
        .o_data  (alu_data)
    );

    char_port u_port (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rx_wr    (i_rx_wr),
        .i_rx_data  (i_rx_data),
        .i_rx_take  (rx_take),
        .i_tx_load  (tx_load),
        .i_tx_char  (tx_char),
        .o_rx_ready (rx_ready),
        .o_rx_char  (rx_char),
        .o_tx_wr    (o_tx_wr),
        .o_tx_data  (o_tx_data)
    );

endmodule

/* design/char_port.sv */
// Character input buffer and output register.
// A new input byte overwrites one not yet read; strobe beats read.
// The output strobe lasts exactly one clock per load.
`timescale 1ns/1ps

module char_port import ucpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_rx_wr,
    input  char_t i_rx_data,
    input  logic  i_rx_take,
    input  logic  i_tx_load,
    input  char_t i_tx_char,
    output logic  o_rx_ready,
    output char_t o_rx_char,
    output logic  o_tx_wr,
    output char_t o_tx_data
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx_ready <= 1'b0;
            o_tx_wr    <= 1'b0;
        end else begin
            if (i_rx_wr) begin
                o_rx_ready <= 1'b1;
            end else if (i_rx_take) begin
                o_rx_ready <= 1'b0;
            end
            o_tx_wr <= i_tx_load;            // one pulse per tx!
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rx_wr) begin
            o_rx_char <= i_rx_data;
        end
        if (i_tx_load) begin
            o_tx_data <= i_tx_char;
        end
    end

endmodule

/* design/ucode_sequencer.sv */
// Four-phase microcode engine: fetch, decode, execute, write-back.
// Every instruction takes exactly four clocks; fetch waits while not running.
// Stack, memory, ALU and port controls are decoded from the current phase
// and act on the following clock edge.
// An undefined opcode clears status, which holds until reset.
`timescale 1ns/1ps

module ucode_sequencer import ucpu_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_run,
    input  cell_t   i_rdata,
    input  cell_t   i_d0,
    input  cell_t   i_d1,
    input  cell_t   i_r0,
    input  cell_t   i_alu_data,
    input  logic    i_rx_ready,
    input  char_t   i_rx_char,
    input  logic    i_tx_busy,
    output logic    o_mem_wr,
    output addr_t   o_mem_waddr,
    output cell_t   o_mem_wdata,
    output addr_t   o_mem_raddr,
    output logic    o_d_push,
    output logic    o_d_pop,
    output cell_t   o_d_value,
    output logic    o_r_push,
    output logic    o_r_pop,
    output cell_t   o_r_value,
    output alu_op_t o_alu_op,
    output cell_t   o_alu_arg0,
    output cell_t   o_alu_arg1,
    output logic    o_rx_take,
    output logic    o_tx_load,
    output char_t   o_tx_char,
    output logic    o_running,
    output logic    o_status
);

    phase_t phase;
    addr_t  pc;
    cell_t  opcode;                          // instruction latched in decode
    logic   status;
    logic   pc_load;
    addr_t  pc_target;
    logic   fault;

    assign o_running = i_run & status;
    assign o_status  = status;
    assign o_tx_char = i_d0[CHAR_W-1:0];

    always_comb begin
        o_mem_wr    = 1'b0;
        o_mem_waddr = i_d0[ADDR_W-1:0];
        o_mem_wdata = i_d1;
        o_mem_raddr = pc;                    // instruction fetch by default
        o_d_push    = 1'b0;
        o_d_pop     = 1'b0;
        o_d_value   = i_alu_data;
        o_r_push    = 1'b0;
        o_r_pop     = 1'b0;
        o_r_value   = i_d0;
        o_alu_op    = ALU_PASS;
        o_alu_arg0  = i_d0;
        o_alu_arg1  = i_d1;
        o_rx_take   = 1'b0;
        o_tx_load   = 1'b0;
        pc_load     = 1'b0;
        pc_target   = pc + 1'b1;
        fault       = 1'b0;
        case (phase)
            PH_DECODE: begin
                case (i_rdata)               // start ALU and memory work early
                    UC_ADD: begin
                        o_alu_op = ALU_ADD;
                        o_d_pop  = 1'b1;
                    end
                    UC_AND: begin
                        o_alu_op = ALU_AND;
                        o_d_pop  = 1'b1;
                    end
                    UC_XOR: begin
                        o_alu_op = ALU_XOR;
                        o_d_pop  = 1'b1;
                    end
                    UC_ROL:   o_alu_op = ALU_ROL;
                    UC_INC: begin
                        o_alu_op   = ALU_ADD;
                        o_alu_arg1 = cell_t'(1);
                    end
                    UC_FETCH: o_mem_raddr = i_d0[ADDR_W-1:0];
                    UC_STORE: begin
                        o_mem_wr = 1'b1;     // first of two pops
                        o_d_pop  = 1'b1;
                    end
                    UC_SWAP:  o_d_pop = 1'b1; // b goes through the ALU
                    default:  ;
                endcase
            end
            PH_EXECUTE: begin
                case (opcode)
                    UC_NOP:   ;
                    UC_ADD, UC_AND, UC_XOR, UC_ROL, UC_INC, UC_SWAP: begin
                        o_d_push = 1'b1;     // replace top with the ALU result
                        o_d_pop  = 1'b1;
                    end
                    UC_FETCH: begin
                        o_d_value = i_rdata;
                        o_d_push  = 1'b1;
                        o_d_pop   = 1'b1;
                    end
                    UC_STORE: o_d_pop = 1'b1;
                    UC_DUP: begin
                        o_d_value = i_d0;
                        o_d_push  = 1'b1;
                    end
                    UC_DROP:  o_d_pop = 1'b1;
                    UC_SKZ: begin
                        pc_load = (i_d0 == CELL_FALSE);
                        o_d_pop = 1'b1;
                    end
                    UC_PUSH_R: begin
                        o_r_push = 1'b1;
                        o_d_pop  = 1'b1;
                    end
                    UC_R_POP: begin
                        o_d_value = i_r0;
                        o_d_push  = 1'b1;
                        o_r_pop   = 1'b1;
                    end
                    UC_EXIT: begin
                        pc_load   = 1'b1;
                        pc_target = i_r0[ADDR_W-1:0];
                        o_r_pop   = 1'b1;
                    end
                    UC_RX_OK: begin
                        o_d_value = i_rx_ready ? CELL_TRUE : CELL_FALSE;
                        o_d_push  = 1'b1;
                    end
                    UC_GET_RX: begin
                        o_d_value = cell_t'(i_rx_char);
                        o_d_push  = 1'b1;
                        o_rx_take = 1'b1;
                    end
                    UC_TX_OK: begin
                        o_d_value = i_tx_busy ? CELL_FALSE : CELL_TRUE;
                        o_d_push  = 1'b1;
                    end
                    UC_SET_TX: begin
                        o_tx_load = 1'b1;
                        o_d_pop   = 1'b1;
                    end
                    default: begin
                        if (opcode[DATA_W-1]) begin
                            // return address gets its upper bits set, like a call word
                            o_r_value = {{(DATA_W-ADDR_W){1'b1}}, pc};
                            o_r_push  = 1'b1;
                            pc_load   = 1'b1;
                            pc_target = opcode[ADDR_W-1:0];
                        end else begin
                            fault = 1'b1;
                        end
                    end
                endcase
            end
            PH_WRITEBACK: begin
                if (opcode == UC_SWAP) begin
                    o_d_push = 1'b1;         // a passed through the ALU in execute
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase  <= PH_FETCH;
            pc     <= '0;
            opcode <= UC_NOP;
            status <= 1'b1;
        end else begin
            case (phase)
                PH_FETCH: begin
                    if (o_running) begin
                        phase <= PH_DECODE;  // memory word is ready next cycle
                    end
                end
                PH_DECODE: begin
                    phase  <= PH_EXECUTE;
                    opcode <= i_rdata;
                    pc     <= pc + 1'b1;
                end
                PH_EXECUTE: begin
                    phase <= PH_WRITEBACK;
                    if (pc_load) begin
                        pc <= pc_target;
                    end
                    if (fault) begin
                        status <= 1'b0;
                    end
                end
                default: phase <= PH_FETCH;
            endcase
        end
    end

endmodule

/* design/alu.sv */
// Registered ALU, the result follows its inputs by one clock.
// Unknown op codes behave as pass.
`timescale 1ns/1ps

module alu import ucpu_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  alu_op_t i_op,
    input  cell_t   i_arg0,
    input  cell_t   i_arg1,
    output cell_t   o_data
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else begin
            case (i_op)
                ALU_PASS: o_data <= i_arg0;
                ALU_ADD:  o_data <= i_arg0 + i_arg1;
                ALU_AND:  o_data <= i_arg0 & i_arg1;
                ALU_XOR:  o_data <= i_arg0 ^ i_arg1;
                ALU_ROL:  o_data <= {i_arg0[DATA_W-2:0], i_arg0[DATA_W-1]};
                default:  o_data <= i_arg0;
            endcase
        end
    end

endmodule

/* design/lifo_stack.sv */
// Register-file stack of STACK_DEPTH cells with its top two cells exposed.
// Push adds a cell, pop removes one, both together replace the top.
// The pointer wraps silently, so overflow and underflow go unnoticed.
// Cell contents are undefined until written.
`timescale 1ns/1ps

module lifo_stack import ucpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_push,
    input  logic  i_pop,
    input  cell_t i_data,
    output cell_t o_s0,
    output cell_t o_s1
);

    typedef logic [$clog2(STACK_DEPTH)-1:0] ptr_t;

    cell_t cells [STACK_DEPTH];
    ptr_t  sp;                               // index of the top cell
    ptr_t  sp_next;

    always_comb begin
        case ({i_push, i_pop})
            2'b10:   sp_next = sp + 1'b1;
            2'b01:   sp_next = sp - 1'b1;
            default: sp_next = sp;           // idle, or replace top in place
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sp <= '0;
        end else begin
            sp <= sp_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            cells[sp_next] <= i_data;        // new top, or overwrite when popping too
        end
    end

    assign o_s0 = cells[sp];
    assign o_s1 = cells[sp - 1'b1];

endmodule

/* design/ucode_mem.sv */
// Program memory, 1024 x 16, one write port and one registered read port.
// Contents come from the hex image at elaboration; there is no reset.
// A read of the address being written returns the old word.
`timescale 1ns/1ps

module ucode_mem import ucpu_pkg::*; (
    input  logic  i_clk,
    input  logic  i_wr,
    input  addr_t i_waddr,
    input  cell_t i_wdata,
    input  addr_t i_raddr,
    output cell_t o_rdata
);

    cell_t mem [0:(1 << ADDR_W)-1];          // block ram

    initial begin
        $readmemh(UCODE_FILE, mem);
    end

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];             // read every cycle, data one cycle later
    end

endmodule

/* design/ucpu_pkg.sv */
// Shared widths, cell types, opcodes and the sequencer phase encoding.
// Opcode values must agree with the words in the microcode image.
// Any word with bit 15 set is a call and is not listed here.
// Undefined opcodes below 0x8000 (0x000E among them) fault the CPU.
package ucpu_pkg;

    localparam int DATA_W      = 16;             // memory word and stack cell
    localparam int ADDR_W      = 10;             // 1024-word program memory
    localparam int CHAR_W      = 8;
    localparam int STACK_DEPTH = 16;             // entries per stack, no overflow check

    typedef logic [DATA_W-1:0] cell_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CHAR_W-1:0] char_t;

    localparam cell_t CELL_TRUE  = 16'hFFFF;     // boolean true is all ones
    localparam cell_t CELL_FALSE = 16'h0000;

    // primitive instructions, stack effect in the usual forth notation
    localparam cell_t UC_NOP     = 16'h0000;     // ( -- )
    localparam cell_t UC_ADD     = 16'h0001;     // ( a b -- a+b )
    localparam cell_t UC_AND     = 16'h0002;     // ( a b -- a&b )
    localparam cell_t UC_XOR     = 16'h0003;     // ( a b -- a^b )
    localparam cell_t UC_ROL     = 16'h0004;     // ( a -- a rotated left by one )
    localparam cell_t UC_INC     = 16'h0005;     // ( a -- a+1 )
    localparam cell_t UC_FETCH   = 16'h0006;     // ( addr -- cell )
    localparam cell_t UC_STORE   = 16'h0007;     // ( cell addr -- )
    localparam cell_t UC_DUP     = 16'h0008;     // ( a -- a a )
    localparam cell_t UC_DROP    = 16'h0009;     // ( a -- )
    localparam cell_t UC_SWAP    = 16'h000A;     // ( a b -- b a )
    localparam cell_t UC_SKZ     = 16'h000B;     // ( cond -- ) skip next word if zero
    localparam cell_t UC_PUSH_R  = 16'h000C;     // ( a -- ) R:( -- a )
    localparam cell_t UC_R_POP   = 16'h000D;     // ( -- a ) R:( a -- )
    localparam cell_t UC_EXIT    = 16'h000F;     // R:( addr -- ) return
    localparam cell_t UC_RX_OK   = 16'h003C;     // ( -- ready )
    localparam cell_t UC_GET_RX  = 16'h003D;     // ( -- char )
    localparam cell_t UC_TX_OK   = 16'h003E;     // ( -- ready )
    localparam cell_t UC_SET_TX  = 16'h003F;     // ( char -- )

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_PASS = 3'd0;         // result is arg0
    localparam alu_op_t ALU_ADD  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_XOR  = 3'd3;
    localparam alu_op_t ALU_ROL  = 3'd4;

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_DECODE,
        PH_EXECUTE,
        PH_WRITEBACK
    } phase_t;

    localparam string UCODE_FILE = "ucode.hex";  // looked up in the simulator's run directory

endpackage
